// File: design/acqCounter.sv
`timescale 1ns/1ps

module acqCounter (
    input  logic clk,
    input  logic rst,
    input  histoPkg::histoState state,
    input  logic accept,
    output histoPkg::binAddr binIdx,
    output logic binLast,
    output logic sampleLast,
    output histoPkg::pixelIdx pixelIdx,
    output logic pixelLast
);
    import histoPkg::*;

    sampleIdx sampleCnt;

    // bin index walks the RAM in CLEAR and SCAN
    always_ff @(posedge clk) begin
        if (rst) begin
            binIdx <= '0;
        end else if ((state == CLEAR) || (state == SCAN)) begin
            binIdx <= binIdx + 1'b1;
        end else begin
            // parked at zero so each state entry starts at bin 0
            binIdx <= '0;
        end
    end

    // accepted samples of the current pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            sampleCnt <= '0;
        end else if (state != ACQUIRE) begin
            sampleCnt <= '0;
        end else if (accept) begin
            sampleCnt <= sampleCnt + 1'b1;
        end
    end

    // pixel index steps once per report
    always_ff @(posedge clk) begin
        if (rst || (state == IDLE)) begin
            pixelIdx <= '0;
        end else if (state == REPORT) begin
            pixelIdx <= pixelIdx + 1'b1;
        end
    end

    assign binLast = (binIdx == '1);

    // flags the acceptance that completes the pixel
    assign sampleLast = accept && (state == ACQUIRE)
                        && (sampleCnt == sampleIdxW'(sampleTotal - 1));

    assign pixelLast = (pixelIdx == pixelIdxW'(pixelNum - 1));

    // wrEn must drop right after the last accepted sample
    assert property (@(posedge clk) disable iff (rst) sampleCnt <= sampleIdxW'(sampleTotal))
        else $error("sample count past ACQ_NUM*DATA_NUM");

endmodule

// File: design/binUpdater.sv
`timescale 1ns/1ps

module binUpdater (
    input  logic clk,
    input  logic rst,
    input  logic sample,
    input  histoPkg::sampleWord word,
    output logic re,
    output histoPkg::binAddr raddr,
    input  histoPkg::binCount rdata,
    output logic we,
    output histoPkg::binAddr waddr,
    output histoPkg::binCount wdata
);
    import histoPkg::*;

    // stage 1 control and address
    logic s1Valid;
    binAddr s1Addr;

    // last write, for same-bin forwarding
    logic lastWe;
    binAddr lastAddr;
    binCount lastData;

    // count before increment
    binCount base;

    // stage 0 skips no-photon words and reads the coarse bin
    assign re = sample && (word.raw != '1);
    assign raddr = word.tof.coarse;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            lastWe <= 1'b0;
        end else begin
            s1Valid <= re;
            lastWe <= we;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr <= raddr;
        lastAddr <= waddr;
        lastData <= wdata;
    end

    // RAM data is stale when the previous cycle wrote the same bin
    assign base = (lastWe && (lastAddr == s1Addr)) ? lastData : rdata;

    // stage 1 does the saturating increment and write back
    assign we = s1Valid;
    assign waddr = s1Addr;
    assign wdata = (base == '1) ? base : base + 1'b1;

    // back-to-back writes to one bin only climb, so no wrap past 255
    assert property (@(posedge clk) disable iff (rst)
        we && $past(we) && (waddr == $past(waddr)) |-> wdata >= $past(wdata))
        else $error("bin count wrapped or dropped");

endmodule

// File: design/histoFsm.sv
`timescale 1ns/1ps

module histoFsm (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic binLast,
    input  logic sampleLast,
    input  logic pixelLast,
    output histoPkg::histoState state,
    output logic wrEn,
    output logic scanRead,
    output logic peakValid,
    output logic done
);
    import histoPkg::*;

    histoState nextState;

    // second DRAIN cycle marker
    logic drainHold;

    // extra SCAN cycle for the RAM read latency
    logic scanTail;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                // start only counts while idle
                if (start) begin
                    nextState = CLEAR;
                end
            end
            CLEAR: begin
                // 64 zero writes, one per bin
                if (binLast) begin
                    nextState = ACQUIRE;
                end
            end
            ACQUIRE: begin
                if (sampleLast) begin
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                // let the final read-modify-write land
                if (drainHold) begin
                    nextState = SCAN;
                end
            end
            SCAN: begin
                if (scanTail) begin
                    nextState = REPORT;
                end
            end
            REPORT: begin
                // next pixel starts right away, last one goes idle
                nextState = pixelLast ? IDLE : CLEAR;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            wrEn <= 1'b0;
            drainHold <= 1'b0;
            scanTail <= 1'b0;
        end else begin
            state <= nextState;
            // registered from next state, so high exactly in ACQUIRE
            wrEn <= (nextState == ACQUIRE);
            drainHold <= (state == DRAIN) && !drainHold;
            // set after bin 63 is addressed, clears in REPORT
            scanTail <= (state == SCAN) && binLast && !scanTail;
        end
    end

    // reads only during the 64 addressing cycles of SCAN
    assign scanRead = (state == SCAN) && !scanTail;

    // peakFinder result is final in REPORT
    assign peakValid = (state == REPORT);
    assign done = peakValid && pixelLast;

    // accepting samples and scanning share the RAM read port
    assert property (@(posedge clk) disable iff (rst) !(wrEn && scanRead))
        else $error("wrEn and scanRead high together");

endmodule

// File: design/histoPkg.sv
`include "histo_params.svh"

package histoPkg;

    // histogram depth
    localparam int binNum = 1 << `BIN_BITS;

    // samples accepted per pixel
    localparam int sampleTotal = `ACQ_NUM * `DATA_NUM;

    // one spare bit so the counter can reach sampleTotal
    localparam int sampleIdxW = $clog2(sampleTotal) + 1;

    localparam int pixelNum = `PIXEL_NUM;
    localparam int pixelIdxW = $clog2(`PIXEL_NUM);

    typedef logic [`BIN_BITS-1:0] binAddr;
    typedef logic [`PEAK_MAX-1:0] binCount;
    typedef logic [sampleIdxW-1:0] sampleIdx;
    typedef logic [pixelIdxW-1:0] pixelIdx;

    // coarse bin above the fine interpolation bits
    typedef struct packed {
        logic [`BIN_BITS-1:0] coarse;
        logic [`FINE_BITS-1:0] fine;
    } tofFields;

    // raw view flags "no photon" as all ones
    typedef union packed {
        logic [`NP-1:0] raw;
        tofFields tof;
    } sampleWord;

    // per-pixel sequence
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        ACQUIRE,
        DRAIN,
        SCAN,
        REPORT
    } histoState;

endpackage

// File: design/histoRam.sv
`timescale 1ns/1ps

module histoRam (
    input  logic clk,
    input  logic we,
    input  histoPkg::binAddr waddr,
    input  histoPkg::binCount wdata,
    input  logic re,
    input  histoPkg::binAddr raddr,
    output histoPkg::binCount rdata
);
    import histoPkg::*;

    // one counter per coarse bin
    binCount mem [binNum];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read
    // same-address write in this cycle returns the old count
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: design/histo_params.svh
`ifndef HISTO_PARAMS_SVH
`define HISTO_PARAMS_SVH

// timestamp word width from the TDC
`define NP 10

// low fine bits dropped before binning
`define FINE_BITS 4

// coarse field addresses the histogram
`define BIN_BITS (`NP - `FINE_BITS)

// bin counter width with saturation at all ones
`define PEAK_MAX 8

// pixels handled one after another in each frame
`define PIXEL_NUM 4

// acquisitions per pixel
`define ACQ_NUM 8

// samples per acquisition
`define DATA_NUM 40

`endif

// File: design/peakFinder.sv
`timescale 1ns/1ps

module peakFinder (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic binValid,
    input  histoPkg::binAddr binIdx,
    input  histoPkg::binCount binData,
    output histoPkg::binAddr peakBin,
    output histoPkg::binCount peakCount
);
    import histoPkg::*;

    // running maximum of the current scan
    binAddr runBin;
    binCount runCount;

    // strictly greater, so ties keep the lower bin
    logic newBest;

    assign newBest = binValid && (binData > runCount);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            // empty histogram ends as bin 0, count 0
            runBin <= '0;
            runCount <= '0;
        end else if (newBest) begin
            runBin <= binIdx;
            runCount <= binData;
        end
    end

    // result taken on the last bin, held until the next scan ends
    always_ff @(posedge clk) begin
        if (rst) begin
            peakBin <= '0;
            peakCount <= '0;
        end else if (binValid && (binIdx == '1)) begin
            peakBin <= newBest ? binIdx : runBin;
            peakCount <= newBest ? binData : runCount;
        end
    end

endmodule

// File: design/sifhTop.sv
`timescale 1ns/1ps

module sifhTop (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic dataValid,
    input  histoPkg::sampleWord data,
    output logic wrEn,
    output logic peakValid,
    output histoPkg::binAddr peakBin,
    output histoPkg::binCount peakCount,
    output histoPkg::pixelIdx peakPixel,
    output logic done
);
    import histoPkg::*;

    histoState state;
    logic accept;
    logic binLast;
    logic sampleLast;
    logic pixelLast;
    logic scanRead;
    binAddr binIdx;

    // binUpdater side of the RAM
    logic updRe;
    binAddr updRaddr;
    logic updWe;
    binAddr updWaddr;
    binCount updWdata;

    // muxed RAM ports
    logic ramWe;
    binAddr ramWaddr;
    binCount ramWdata;
    logic ramRe;
    binAddr ramRaddr;
    binCount ramRdata;

    // scan stream aligned to the read latency
    logic scanReadD;
    binAddr binIdxD;
    logic peakClear;

    // dataValid outside ACQUIRE is dropped here
    assign accept = wrEn && dataValid;

    histoFsm fsm (
        .clk(clk),
        .rst(rst),
        .start(start),
        .binLast(binLast),
        .sampleLast(sampleLast),
        .pixelLast(pixelLast),
        .state(state),
        .wrEn(wrEn),
        .scanRead(scanRead),
        .peakValid(peakValid),
        .done(done)
    );

    acqCounter counters (
        .clk(clk),
        .rst(rst),
        .state(state),
        .accept(accept),
        .binIdx(binIdx),
        .binLast(binLast),
        .sampleLast(sampleLast),
        .pixelIdx(peakPixel),
        .pixelLast(pixelLast)
    );

    binUpdater updater (
        .clk(clk),
        .rst(rst),
        .sample(accept),
        .word(data),
        .re(updRe),
        .raddr(updRaddr),
        .rdata(ramRdata),
        .we(updWe),
        .waddr(updWaddr),
        .wdata(updWdata)
    );

    // CLEAR zeroes bin by bin, otherwise updater writes
    assign ramWe = (state == CLEAR) ? 1'b1 : updWe;
    assign ramWaddr = (state == CLEAR) ? binIdx : updWaddr;
    assign ramWdata = (state == CLEAR) ? '0 : updWdata;

    // SCAN owns the read port
    assign ramRe = scanRead ? 1'b1 : updRe;
    assign ramRaddr = scanRead ? binIdx : updRaddr;

    histoRam ram (
        .clk(clk),
        .we(ramWe),
        .waddr(ramWaddr),
        .wdata(ramWdata),
        .re(ramRe),
        .raddr(ramRaddr),
        .rdata(ramRdata)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            scanReadD <= 1'b0;
        end else begin
            scanReadD <= scanRead;
        end
    end

    always_ff @(posedge clk) begin
        binIdxD <= binIdx;
    end

    // first scan cycle addresses bin 0
    assign peakClear = scanRead && (binIdx == '0);

    peakFinder finder (
        .clk(clk),
        .rst(rst),
        .clear(peakClear),
        .binValid(scanReadD),
        .binIdx(binIdxD),
        .binData(ramRdata),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

endmodule

// File: sources.f
+incdir+design
design/histoPkg.sv
design/histoRam.sv
design/binUpdater.sv
design/peakFinder.sv
design/acqCounter.sv
design/histoFsm.sv
design/sifhTop.sv
tests/sifhTopTb.sv

// File: tests/sifhTopTb.sv
`timescale 1ns/1ps
`include "histo_params.svh"

module sifhTopTb;
    import histoPkg::*;

    localparam int rowNum = 8;
    localparam int countMax = (1 << `PEAK_MAX) - 1;
    localparam int wrEnLimit = 200;
    localparam int acqLimit = 2000;
    localparam int peakLimit = 300;

    typedef logic [`FINE_BITS-1:0] fineBits;

    logic clk;
    logic rst;
    logic start;
    logic dataValid;
    sampleWord data;
    logic wrEn;
    logic peakValid;
    binAddr peakBin;
    binCount peakCount;
    pixelIdx peakPixel;
    logic done;

    // stimulus table with one row per pixel
    // pairBin is -1 for rows with a single hot bin
    string rowName [rowNum];
    int rowHotBin [rowNum];
    int rowPairBin [rowNum];
    int rowHotProb [rowNum];
    int rowNullProb [rowNum];
    bit rowBurst [rowNum];
    int rowFill;

    // reference histogram of the accepted words
    int hist [binNum];
    logic [31:0] lfsr;
    int errorCount;
    int testsFailed;
    bit timedOut;

    sifhTop UUT (
        .clk(clk),
        .rst(rst),
        .start(start),
        .dataValid(dataValid),
        .data(data),
        .wrEn(wrEn),
        .peakValid(peakValid),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .peakPixel(peakPixel),
        .done(done)
    );

    always #2 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    function automatic int randBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic addRow(input string name, input int hotBin, input int pairBin,
                          input int hotProb, input int nullProb, input bit burst);
        rowName[rowFill] = name;
        rowHotBin[rowFill] = hotBin;
        rowPairBin[rowFill] = pairBin;
        rowHotProb[rowFill] = hotProb;
        rowNullProb[rowFill] = nullProb;
        rowBurst[rowFill] = burst;
        rowFill++;
    endtask

    task automatic checkValue(input string test, input string field,
                              input int expected, input int actual);
        assert (expected == actual) else begin
            $display("FAIL %s %s expected %0d actual %0d", test, field, expected, actual);
            errorCount++;
        end
    endtask

    // first maximum wins, empty histogram gives bin 0
    task automatic expectedPeak(output int bin, output int count);
        bin = 0;
        count = 0;
        for (int b = 0; b < binNum; b++) begin
            if (hist[b] > count) begin
                bin = b;
                count = hist[b];
            end
        end
    endtask

    task automatic pulseStart();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic waitWrEn(input int row);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wrEn && cycles < wrEnLimit) begin
            @(negedge clk);
            cycles++;
        end
        assert (wrEn) else begin
            $display("timeout: wrEn never rose in test %s", rowName[row]);
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    task automatic runAcquire(input int row);
        int accepted;
        int cycles;
        bit valid;
        bit pairSel;
        sampleWord w;
        accepted = 0;
        cycles = 0;
        pairSel = 1'b0;
        while (accepted < sampleTotal && cycles < acqLimit) begin
            @(posedge clk);
            valid = rowBurst[row] || (randBits(2) != 0);
            // idle cycles carry a hot word that must be ignored
            w.tof.coarse = binAddr'(rowHotBin[row]);
            w.tof.fine = '0;
            if (valid) begin
                w.tof.fine = fineBits'(randBits(`FINE_BITS));
                if (randBits(8) < rowNullProb[row]) begin
                    w.raw = '1;
                end else if (randBits(8) < rowHotProb[row]) begin
                    // pair rows alternate between the two hot bins
                    if (pairSel && rowPairBin[row] >= 0) begin
                        w.tof.coarse = binAddr'(rowPairBin[row]);
                    end
                    pairSel = !pairSel;
                end else begin
                    w.tof.coarse = binAddr'(randBits(`BIN_BITS));
                end
            end
            dataValid <= valid;
            data <= w;
            @(negedge clk);
            cycles++;
            // taken by the DUT at the coming edge
            if (wrEn && dataValid) begin
                accepted++;
                if (data.raw != '1 && hist[data.tof.coarse] < countMax) begin
                    hist[data.tof.coarse]++;
                end
            end
        end
        @(posedge clk);
        dataValid <= 1'b0;
        assert (accepted == sampleTotal) else begin
            $display("timeout: only %0d samples taken in test %s", accepted, rowName[row]);
            errorCount++;
            timedOut = 1'b1;
        end
        @(negedge clk);
        // wrEn drops right after the last sample of the pixel
        checkValue(rowName[row], "wrEn after last sample", 0, int'(wrEn));
    endtask

    task automatic checkPeak(input int row);
        int cycles;
        int expBin;
        int expCount;
        cycles = 0;
        @(negedge clk);
        while (!peakValid && cycles < peakLimit) begin
            assert (!done) else begin
                $display("done pulsed without peakValid in test %s", rowName[row]);
                errorCount++;
            end
            @(negedge clk);
            cycles++;
        end
        assert (peakValid) else begin
            $display("timeout: peakValid never came in test %s", rowName[row]);
            errorCount++;
            timedOut = 1'b1;
        end
        if (peakValid) begin
            expectedPeak(expBin, expCount);
            checkValue(rowName[row], "peakBin", expBin, int'(peakBin));
            checkValue(rowName[row], "peakCount", expCount, int'(peakCount));
            checkValue(rowName[row], "peakPixel", row % `PIXEL_NUM, int'(peakPixel));
            checkValue(rowName[row], "done", int'(row % `PIXEL_NUM == `PIXEL_NUM - 1),
                       int'(done));
            @(negedge clk);
            checkValue(rowName[row], "peakValid second cycle", 0, int'(peakValid));
        end
    endtask

    initial begin
        int errBefore;
        int row;
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        dataValid = 1'b0;
        data = '0;
        lfsr = 32'hee66;
        errorCount = 0;
        testsFailed = 0;
        timedOut = 1'b0;
        rowFill = 0;
        // name, hot bin, pair bin, hot and null odds out of 256, burst
        addRow("hotBin", 17, -1, 128, 16, 1'b0);
        addRow("sameBinRun", 42, -1, 160, 0, 1'b1);
        addRow("allNull", 0, -1, 0, 256, 1'b0);
        addRow("saturate", 5, -1, 256, 0, 1'b0);
        addRow("tieLowBin", 50, 12, 256, 0, 1'b0);
        addRow("gapHeavy", 60, -1, 64, 64, 1'b0);
        addRow("uniform", 0, -1, 0, 32, 1'b0);
        addRow("topBin", 63, -1, 96, 0, 1'b1);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("reset", "wrEn", 0, int'(wrEn));
        checkValue("reset", "peakValid", 0, int'(peakValid));
        checkValue("reset", "done", 0, int'(done));
        row = 0;
        while (row < rowNum && !timedOut) begin
            errBefore = errorCount;
            // each frame begins with a start pulse
            if (row % `PIXEL_NUM == 0) begin
                pulseStart();
            end
            for (int b = 0; b < binNum; b++) begin
                hist[b] = 0;
            end
            waitWrEn(row);
            if (!timedOut) begin
                runAcquire(row);
            end
            if (!timedOut) begin
                checkPeak(row);
            end
            if (errorCount == errBefore) begin
                $display("test %s ok", rowName[row]);
            end else begin
                testsFailed++;
                $display("test %s had %0d errors", rowName[row], errorCount - errBefore);
            end
            row++;
        end
        $display("tests run %0d, failed %0d, errors %0d", row, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
